/* common/IntExecPkg.sv */
/*
 * Shared widths, operation encodings and the sub-info word of the integer
 * execution lane. Modules take these by a wildcard import in their header.
 * The stage uses the flush-range function for selective flush.
 */
`default_nettype none

package IntExecPkg;

    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 32;
    localparam int AL_PTR_WIDTH    = 5;
    localparam int SHIFT_AMT_WIDTH = 5;
    localparam int INSN_BYTES      = 4;

    typedef logic [DATA_WIDTH-1:0]   DataPath;
    typedef logic [ADDR_WIDTH-1:0]   AddrPath;
    typedef logic [AL_PTR_WIDTH-1:0] ActiveListPtr;

    typedef enum logic [2:0] {
        INT_OP_ALU    = 3'd0,
        INT_OP_SHIFT  = 3'd1,
        INT_OP_BR     = 3'd2,
        INT_OP_RIJ    = 3'd3,
        INT_OP_SELECT = 3'd4
    } IntOpType;

    typedef enum logic [2:0] {
        COND_EQ    = 3'd0,
        COND_NE    = 3'd1,
        COND_LT    = 3'd2,
        COND_LTU   = 3'd3,
        COND_GE    = 3'd4,
        COND_GEU   = 3'd5,
        COND_AL    = 3'd6,
        COND_NEVER = 3'd7
    } CondCode;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_SLTU = 3'd6
    } AluCode;

    typedef enum logic [1:0] {
        SHIFT_SLL = 2'd0,
        SHIFT_SRL = 2'd1,
        SHIFT_SRA = 2'd2
    } ShiftKind;

    typedef enum logic {
        OPERAND_REG = 1'b0,
        OPERAND_IMM = 1'b1
    } OperandKind;

    // ALU and shift form, 13 used bits
    typedef struct packed {
        AluCode                     aluCode;
        ShiftKind                   shiftKind;
        logic                       shiftFromImm;
        logic [SHIFT_AMT_WIDTH-1:0] shiftAmt;
        OperandKind                 operandKindA;
        OperandKind                 operandKindB;
        logic [6:0]                 padding;
    } IntAluSubInfo;

    // Branch and select form
    typedef struct packed {
        CondCode            cond;
        logic signed [16:0] disp;
    } IntBrSubInfo;

    // Op type picks the view
    typedef union packed {
        IntAluSubInfo alu;
        IntBrSubInfo  br;
    } IntSubInfo;

    // Pointer lies in [head, tail) on the circular active list
    function automatic logic InFlushRange(
        input ActiveListPtr head,
        input ActiveListPtr tail,
        input ActiveListPtr ptr
    );
        ActiveListPtr ptrOffset;
        ActiveListPtr rangeSize;
        ptrOffset = ptr - head;
        rangeSize = tail - head;
        return ptrOffset < rangeSize;
    endfunction

endpackage

`default_nettype wire

/* intExec/BranchResolver.sv */
/*
 * Branch resolution for BR and RIJ ops.
 * Evaluates the condition, picks the next address and compares it with the
 * prediction. The condition also drives the select operation in the stage.
 */
`timescale 1ns/1ps
`default_nettype none

module BranchResolver
    import IntExecPkg::*;
(
    input  IntOpType           opType,
    input  CondCode            cond,
    input  logic signed [16:0] disp,
    input  AddrPath            pc,
    input  DataPath            opA,
    input  DataPath            opB,
    input  logic               predTaken,
    input  AddrPath            predAddr,
    output logic               condTrue,
    output logic               taken,
    output AddrPath            nextAddr,
    output logic               mispredRaw
);

    AddrPath dispExt;
    AddrPath brTarget;
    AddrPath rijTarget;
    logic    isBranch;

    always_comb begin
        case (cond)
            COND_EQ: begin
                condTrue = opA == opB;
            end
            COND_NE: begin
                condTrue = opA != opB;
            end
            COND_LT: begin
                condTrue = $signed(opA) < $signed(opB);
            end
            COND_LTU: begin
                condTrue = opA < opB;
            end
            COND_GE: begin
                condTrue = $signed(opA) >= $signed(opB);
            end
            COND_GEU: begin
                condTrue = opA >= opB;
            end
            COND_AL: begin
                condTrue = 1'b1;
            end
            default: begin
                // COND_NEVER
                condTrue = 1'b0;
            end
        endcase
    end

    // Sign extend the 17-bit displacement
    assign dispExt = {{(ADDR_WIDTH - 17){disp[16]}}, disp};

    // Direct branch offsets count half-words
    assign brTarget = pc + (dispExt << 1);

    always_comb begin
        rijTarget    = opA + dispExt;
        rijTarget[0] = 1'b0;
    end

    assign isBranch = (opType == INT_OP_BR) || (opType == INT_OP_RIJ);
    assign taken    = isBranch && condTrue;

    always_comb begin
        if (!taken) begin
            nextAddr = pc + AddrPath'(INSN_BYTES);
        end else if (opType == INT_OP_BR) begin
            nextAddr = brTarget;
        end else begin
            nextAddr = rijTarget;
        end
    end

    // Wrong direction, or taken to the wrong place
    assign mispredRaw = (predTaken != taken) || (taken && (predAddr != nextAddr));

endmodule

`default_nettype wire

/* intExec/IntAlu.sv */
/*
 * Combinational integer ALU of the execution lane.
 * Add, subtract, bitwise logic and signed or unsigned set-less-than.
 */
`timescale 1ns/1ps
`default_nettype none

module IntAlu
    import IntExecPkg::*;
(
    input  AluCode  aluCode,
    input  DataPath opA,
    input  DataPath opB,
    output DataPath result
);

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluCode)
            ALU_ADD: begin
                result = opA + opB;
            end
            ALU_SUB: begin
                result = opA - opB;
            end
            ALU_AND: begin
                result = opA & opB;
            end
            ALU_OR: begin
                result = opA | opB;
            end
            ALU_XOR: begin
                result = opA ^ opB;
            end
            ALU_SLT: begin
                result = DataPath'(ltSigned);
            end
            ALU_SLTU: begin
                result = DataPath'(ltUnsigned);
            end
            default: begin
                // Unused encoding
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* intExec/IntShifter.sv */
/*
 * Combinational shifter of the execution lane.
 * Shift amount comes from the immediate field or from operand B.
 */
`timescale 1ns/1ps
`default_nettype none

module IntShifter
    import IntExecPkg::*;
(
    input  ShiftKind                   kind,
    input  logic                       fromImm,
    input  logic [SHIFT_AMT_WIDTH-1:0] immAmt,
    input  logic [SHIFT_AMT_WIDTH-1:0] regAmt,
    input  DataPath                    dataIn,
    output DataPath                    dataOut
);

    logic [SHIFT_AMT_WIDTH-1:0] amt;

    assign amt = fromImm ? immAmt : regAmt;

    always_comb begin
        case (kind)
            SHIFT_SLL: begin
                dataOut = dataIn << amt;
            end
            SHIFT_SRL: begin
                dataOut = dataIn >> amt;
            end
            SHIFT_SRA: begin
                // Sign bit fills from the left
                dataOut = DataPath'($signed(dataIn) >>> amt);
            end
            default: begin
                dataOut = dataIn;
            end
        endcase
    end

endmodule

`default_nettype wire

/* intExec/IntegerExecutionStage.sv */
/*
 * One lane of the integer execution stage.
 * Registers the issued op, runs ALU, shifter and branch resolver on it and
 * reports the result one cycle later. Stall, clear and selective flush only
 * suppress the outputs; under stall the register keeps the op.
 */
`timescale 1ns/1ps
`default_nettype none

module IntegerExecutionStage
    import IntExecPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         issueValid,
    input  IntOpType     opType,
    input  IntSubInfo    subInfo,
    input  AddrPath      pc,
    input  DataPath      operandA,
    input  logic         operandAValid,
    input  DataPath      operandB,
    input  logic         operandBValid,
    input  ActiveListPtr alPtr,
    input  logic         predTaken,
    input  AddrPath      predAddr,
    input  logic         stall,
    input  logic         clear,
    input  logic         flushValid,
    input  ActiveListPtr flushHead,
    input  ActiveListPtr flushTail,
    output logic         exValid,
    output DataPath      exData,
    output logic         exDataValid,
    output logic         brValid,
    output logic         brTaken,
    output AddrPath      brNextAddr,
    output logic         brMispred
);

    logic         pipeValid;
    IntOpType     pipeOpType;
    IntSubInfo    pipeSubInfo;
    AddrPath      pipePc;
    DataPath      pipeOpA;
    logic         pipeOpAValid;
    DataPath      pipeOpB;
    logic         pipeOpBValid;
    ActiveListPtr pipeAlPtr;
    logic         pipePredTaken;
    AddrPath      pipePredAddr;

    IntAluSubInfo aluView;
    IntBrSubInfo  brView;
    DataPath      aluResult;
    DataPath      shiftResult;
    logic         condTrue;
    logic         mispredRaw;
    logic         isBranch;
    logic         isBranchForm;
    logic         condUsesOperands;
    logic         needA;
    logic         needB;
    logic         flushHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOpType    <= opType;
            pipeSubInfo   <= subInfo;
            pipePc        <= pc;
            pipeOpA       <= operandA;
            pipeOpAValid  <= operandAValid;
            pipeOpB       <= operandB;
            pipeOpBValid  <= operandBValid;
            pipeAlPtr     <= alPtr;
            pipePredTaken <= predTaken;
            pipePredAddr  <= predAddr;
        end
    end

    assign aluView = pipeSubInfo.alu;
    assign brView  = pipeSubInfo.br;

    IntAlu u_IntAlu (
        .aluCode (aluView.aluCode),
        .opA     (pipeOpA),
        .opB     (pipeOpB),
        .result  (aluResult)
    );

    IntShifter u_IntShifter (
        .kind    (aluView.shiftKind),
        .fromImm (aluView.shiftFromImm),
        .immAmt  (aluView.shiftAmt),
        .regAmt  (pipeOpB[SHIFT_AMT_WIDTH-1:0]),
        .dataIn  (pipeOpA),
        .dataOut (shiftResult)
    );

    BranchResolver u_BranchResolver (
        .opType     (pipeOpType),
        .cond       (brView.cond),
        .disp       (brView.disp),
        .pc         (pipePc),
        .opA        (pipeOpA),
        .opB        (pipeOpB),
        .predTaken  (pipePredTaken),
        .predAddr   (pipePredAddr),
        .condTrue   (condTrue),
        .taken      (brTaken),
        .nextAddr   (brNextAddr),
        .mispredRaw (mispredRaw)
    );

    always_comb begin
        case (pipeOpType)
            INT_OP_ALU: begin
                exData = aluResult;
            end
            INT_OP_SHIFT: begin
                exData = shiftResult;
            end
            INT_OP_BR, INT_OP_RIJ: begin
                // Link value
                exData = pipePc + DataPath'(INSN_BYTES);
            end
            INT_OP_SELECT: begin
                exData = condTrue ? pipeOpA : pipeOpB;
            end
            default: begin
                exData = '0;
            end
        endcase
    end

    // Branch and select ops carry the branch form with no operand kinds.
    // Their operands count as registers whenever the condition compares them;
    // RIJ also needs operand A for its target.
    assign isBranch         = (pipeOpType == INT_OP_BR) || (pipeOpType == INT_OP_RIJ);
    assign isBranchForm     = isBranch || (pipeOpType == INT_OP_SELECT);
    assign condUsesOperands = (brView.cond != COND_AL) && (brView.cond != COND_NEVER);

    always_comb begin
        if (isBranchForm) begin
            needA = condUsesOperands || (pipeOpType == INT_OP_RIJ);
            needB = condUsesOperands;
        end else begin
            needA = aluView.operandKindA == OPERAND_REG;
            needB = aluView.operandKindB == OPERAND_REG;
        end
    end

    // Low means the op read a stale register and must be replayed
    assign exDataValid = (!needA || pipeOpAValid) && (!needB || pipeOpBValid);

    assign flushHit = flushValid && InFlushRange(flushHead, flushTail, pipeAlPtr);
    assign exValid  = pipeValid && !stall && !clear && !flushHit;

    assign brValid   = pipeValid && isBranch && exDataValid && exValid;
    assign brMispred = brValid && mispredRaw;

endmodule

`default_nettype wire

/* rtl/IntExecUnit.sv */
/*
 * Top level of the integer execution lane subsystem.
 * Exposes the issue, control and result ports of the execution stage.
 */
`timescale 1ns/1ps
`default_nettype none

module IntExecUnit
    import IntExecPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         issueValid,
    input  IntOpType     opType,
    input  IntSubInfo    subInfo,
    input  AddrPath      pc,
    input  DataPath      operandA,
    input  logic         operandAValid,
    input  DataPath      operandB,
    input  logic         operandBValid,
    input  ActiveListPtr alPtr,
    input  logic         predTaken,
    input  AddrPath      predAddr,
    input  logic         stall,
    input  logic         clear,
    input  logic         flushValid,
    input  ActiveListPtr flushHead,
    input  ActiveListPtr flushTail,
    output logic         exValid,
    output DataPath      exData,
    output logic         exDataValid,
    output logic         brValid,
    output logic         brTaken,
    output AddrPath      brNextAddr,
    output logic         brMispred
);

    IntegerExecutionStage u_IntegerExecutionStage (
        .clk           (clk),
        .rstN          (rstN),
        .issueValid    (issueValid),
        .opType        (opType),
        .subInfo       (subInfo),
        .pc            (pc),
        .operandA      (operandA),
        .operandAValid (operandAValid),
        .operandB      (operandB),
        .operandBValid (operandBValid),
        .alPtr         (alPtr),
        .predTaken     (predTaken),
        .predAddr      (predAddr),
        .stall         (stall),
        .clear         (clear),
        .flushValid    (flushValid),
        .flushHead     (flushHead),
        .flushTail     (flushTail),
        .exValid       (exValid),
        .exData        (exData),
        .exDataValid   (exDataValid),
        .brValid       (brValid),
        .brTaken       (brTaken),
        .brNextAddr    (brNextAddr),
        .brMispred     (brMispred)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the integer execution lane testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module IntExecUnitTb \
    -o simv

# The simulation may exit nonzero on failure; the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
else
    exit 1
fi

/* tb/IntExecUnitTb.sv */
/*
 * Testbench of the integer execution lane. Builds a table of issued ops with
 * hand-worked expected results and applies it row by row. Each op is checked
 * one cycle after issue, with that row's stall, clear and flush levels applied.
 */
`timescale 1ns/1ps
`default_nettype none

module IntExecUnitTb
    import IntExecPkg::*;
;

    typedef struct packed {
        IntOpType     opType;
        IntSubInfo    subInfo;
        AddrPath      pc;
        DataPath      opA;
        logic         opAValid;
        DataPath      opB;
        logic         opBValid;
        ActiveListPtr alPtr;
        logic         predTaken;
        AddrPath      predAddr;
        logic         stall;
        logic         clear;
        logic         flushValid;
        ActiveListPtr flushHead;
        ActiveListPtr flushTail;
        logic         expExValid;
        DataPath      expData;
        logic         expDataValid;
        logic         expBrValid;
        logic         expTaken;
        AddrPath      expNext;
        logic         expMispred;
    } Row;

    logic         clk;
    logic         rstN;
    logic         issueValid;
    IntOpType     opType;
    IntSubInfo    subInfo;
    AddrPath      pc;
    DataPath      operandA;
    logic         operandAValid;
    DataPath      operandB;
    logic         operandBValid;
    ActiveListPtr alPtr;
    logic         predTaken;
    AddrPath      predAddr;
    logic         stall;
    logic         clear;
    logic         flushValid;
    ActiveListPtr flushHead;
    ActiveListPtr flushTail;
    logic         exValid;
    DataPath      exData;
    logic         exDataValid;
    logic         brValid;
    logic         brTaken;
    AddrPath      brNextAddr;
    logic         brMispred;

    Row rows[$];
    Row r;
    logic tableReady = 1'b0;

    IntExecUnit u_IntExecUnit (.*);

    bind IntegerExecutionStage IntExecUnitAsserts u_IntExecUnitAsserts (
        .clk       (clk),
        .rstN      (rstN),
        .exValid   (exValid),
        .brValid   (brValid),
        .brMispred (brMispred)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic reportFail(input string msg);
        $display("[FAIL] time %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic checkData(input int idx, input DataPath data, input logic dataValid,
                             input DataPath expData, input logic expValid);
        if (dataValid !== expValid) begin
            reportFail($sformatf("row %0d exDataValid %b, expected %b", idx, dataValid, expValid));
        end
        // Data of a replayed op is don't care
        if (expValid && data !== expData) begin
            reportFail($sformatf("row %0d exData %h, expected %h", idx, data, expData));
        end
    endtask

    task automatic checkBranch(input int idx, input logic valid, input logic taken,
                               input AddrPath next, input logic mispred, input Row e);
        if (valid !== e.expBrValid || mispred !== e.expMispred) begin
            reportFail($sformatf("row %0d brValid/brMispred %b/%b, expected %b/%b",
                                 idx, valid, mispred, e.expBrValid, e.expMispred));
        end
        if (e.expBrValid && (taken !== e.expTaken || next !== e.expNext)) begin
            reportFail($sformatf("row %0d taken %b next %h, expected %b %h",
                                 idx, taken, next, e.expTaken, e.expNext));
        end
    endtask

    task automatic checkRow(input int idx, input Row e);
        if (exValid !== e.expExValid) begin
            reportFail($sformatf("row %0d exValid %b, expected %b",
                                 idx, exValid, e.expExValid));
        end
        if (e.expExValid) begin
            checkData(idx, exData, exDataValid, e.expData, e.expDataValid);
            checkBranch(idx, brValid, brTaken, brNextAddr, brMispred, e);
        end else if (brValid || brMispred) begin
            reportFail($sformatf("row %0d branch outputs active on a dropped op", idx));
        end
    endtask

    function automatic IntSubInfo aluInfo(input AluCode code, input ShiftKind kind,
                                          input logic fromImm, input logic [4:0] amt,
                                          input OperandKind kindA);
        IntSubInfo s;
        s.alu.aluCode      = code;
        s.alu.shiftKind    = kind;
        s.alu.shiftFromImm = fromImm;
        s.alu.shiftAmt     = amt;
        s.alu.operandKindA = kindA;
        s.alu.operandKindB = OPERAND_REG;
        s.alu.padding      = 7'($urandom);
        return s;
    endfunction

    function automatic IntSubInfo brInfo(input CondCode cond, input logic signed [16:0] disp);
        IntSubInfo s;
        s.br.cond = cond;
        s.br.disp = disp;
        return s;
    endfunction

    // Defaults: valid operands, no controls, not-taken prediction
    function automatic Row baseRow(input IntOpType t, input IntSubInfo s,
                                   input DataPath a, input DataPath b, input DataPath d);
        Row x;
        x = '0;
        x.opType = t;
        x.subInfo = s;
        x.pc = 32'h1000;
        x.opA = a;
        x.opAValid = 1'b1;
        x.opB = b;
        x.opBValid = 1'b1;
        x.alPtr = 5'd3;
        x.expExValid = 1'b1;
        x.expData = d;
        x.expDataValid = 1'b1;
        x.expNext = 32'h1004;
        return x;
    endfunction

    function automatic Row alu(input AluCode c, input DataPath a, input DataPath b,
                               input DataPath d);
        return baseRow(INT_OP_ALU, aluInfo(c, SHIFT_SLL, 1'b0, 5'd0, OPERAND_REG), a, b, d);
    endfunction

    function automatic Row shift(input ShiftKind k, input logic imm, input logic [4:0] amt,
                                 input DataPath a, input DataPath b, input DataPath d);
        return baseRow(INT_OP_SHIFT, aluInfo(ALU_ADD, k, imm, amt, OPERAND_REG), a, b, d);
    endfunction

    function automatic Row sel(input CondCode c, input DataPath d);
        return baseRow(INT_OP_SELECT, brInfo(c, 17'sd0), 32'hFFFF_FFFF, 32'h1, d);
    endfunction

    function automatic Row branch(input IntOpType t, input CondCode c,
                                  input logic signed [16:0] disp, input DataPath a,
                                  input DataPath b, input logic taken, input AddrPath next);
        Row x;
        x = baseRow(t, brInfo(c, disp), a, b, 32'h1004);
        x.expBrValid = 1'b1;
        x.expTaken = taken;
        x.expNext = next;
        x.predTaken = taken;
        x.predAddr = next;
        return x;
    endfunction

    task automatic buildTable();
        rows.push_back(alu(ALU_ADD, 32'd5, 32'd7, 32'd12));
        rows.push_back(alu(ALU_SUB, 32'd5, 32'd7, 32'hFFFF_FFFE));
        rows.push_back(alu(ALU_AND, 32'hF0F0, 32'hFF00, 32'hF000));
        rows.push_back(alu(ALU_OR, 32'hF0F0, 32'hFF00, 32'hFFF0));
        rows.push_back(alu(ALU_XOR, 32'hF0F0, 32'hFF00, 32'h0FF0));
        rows.push_back(alu(ALU_SLT, 32'hFFFF_FFFF, 32'h1, 32'h1));
        rows.push_back(alu(ALU_SLTU, 32'hFFFF_FFFF, 32'h1, 32'h0));
        rows.push_back(shift(SHIFT_SLL, 1'b1, 5'd4, 32'h1, 32'h3, 32'h10));
        rows.push_back(shift(SHIFT_SLL, 1'b0, 5'd9, 32'h1, 32'h23, 32'h8));
        rows.push_back(shift(SHIFT_SRL, 1'b1, 5'd1, 32'h8000_0000, 32'h0, 32'h4000_0000));
        rows.push_back(shift(SHIFT_SRL, 1'b0, 5'd0, 32'h8000_0000, 32'd31, 32'h1));
        rows.push_back(shift(SHIFT_SRA, 1'b1, 5'd4, 32'hF000_0000, 32'h0, 32'hFF00_0000));
        rows.push_back(shift(SHIFT_SRA, 1'b0, 5'd0, 32'h8000_0000, 32'd8, 32'hFF80_0000));
        // Operands are -1 and 1, so signed and unsigned orders disagree
        rows.push_back(sel(COND_EQ, 32'h1));
        rows.push_back(sel(COND_NE, 32'hFFFF_FFFF));
        rows.push_back(sel(COND_LT, 32'hFFFF_FFFF));
        rows.push_back(sel(COND_LTU, 32'h1));
        rows.push_back(sel(COND_GE, 32'h1));
        rows.push_back(sel(COND_GEU, 32'hFFFF_FFFF));
        rows.push_back(sel(COND_AL, 32'hFFFF_FFFF));
        rows.push_back(sel(COND_NEVER, 32'h1));
        rows.push_back(branch(INT_OP_BR, COND_EQ, 17'sd16, 32'd5, 32'd5, 1'b1, 32'h1020));
        rows.push_back(branch(INT_OP_BR, COND_NE, 17'sd16, 32'd5, 32'd5, 1'b0, 32'h1004));
        rows.push_back(branch(INT_OP_RIJ, COND_AL, 17'sd4, 32'h2003, 32'h0, 1'b1, 32'h2006));
        // Wrong direction
        r = branch(INT_OP_BR, COND_LT, -17'sd4, 32'd1, 32'd2, 1'b1, 32'h0FF8);
        r.predTaken = 1'b0;
        r.expMispred = 1'b1;
        rows.push_back(r);
        // Right direction, wrong target
        r = branch(INT_OP_RIJ, COND_AL, 17'sd4, 32'h2003, 32'h0, 1'b1, 32'h2006);
        r.predAddr = 32'h2000;
        r.expMispred = 1'b1;
        rows.push_back(r);
        // Replay cases
        r = alu(ALU_ADD, 32'd5, 32'd7, 32'd12);
        r.opAValid = 1'b0;
        r.expDataValid = 1'b0;
        rows.push_back(r);
        r = baseRow(INT_OP_ALU, aluInfo(ALU_ADD, SHIFT_SLL, 1'b0, 5'd0, OPERAND_IMM),
                    32'd5, 32'd7, 32'd12);
        r.opAValid = 1'b0;
        rows.push_back(r);
        r = branch(INT_OP_BR, COND_EQ, 17'sd16, 32'd5, 32'd5, 1'b1, 32'h1020);
        r.opBValid = 1'b0;
        r.expDataValid = 1'b0;
        r.expBrValid = 1'b0;
        rows.push_back(r);
        r = branch(INT_OP_BR, COND_AL, 17'sd8, 32'd0, 32'd0, 1'b1, 32'h1010);
        r.opBValid = 1'b0;
        rows.push_back(r);
        // Controls
        r = alu(ALU_ADD, 32'd1, 32'd2, 32'd3);
        r.stall = 1'b1;
        r.expExValid = 1'b0;
        rows.push_back(r);
        r.stall = 1'b0;
        r.clear = 1'b1;
        rows.push_back(r);
        // alPtr 3 against [2,5), [4,8), the wrapping [30,4) and [30,2)
        r.clear = 1'b0;
        r.flushValid = 1'b1;
        r.flushHead = 5'd2;
        r.flushTail = 5'd5;
        rows.push_back(r);
        r.flushHead = 5'd4;
        r.flushTail = 5'd8;
        r.expExValid = 1'b1;
        rows.push_back(r);
        r.flushHead = 5'd30;
        r.flushTail = 5'd4;
        r.expExValid = 1'b0;
        rows.push_back(r);
        r.flushTail = 5'd2;
        r.expExValid = 1'b1;
        rows.push_back(r);
        r = branch(INT_OP_BR, COND_EQ, 17'sd16, 32'd5, 32'd5, 1'b1, 32'h1020);
        r.flushValid = 1'b1;
        r.flushHead = 5'd30;
        r.flushTail = 5'd4;
        r.expExValid = 1'b0;
        rows.push_back(r);
    endtask

    task automatic driveIssue(input Row x);
        issueValid    = 1'b1;
        opType        = x.opType;
        subInfo       = x.subInfo;
        pc            = x.pc;
        operandA      = x.opA;
        operandAValid = x.opAValid;
        operandB      = x.opB;
        operandBValid = x.opBValid;
        alPtr         = x.alPtr;
        predTaken     = x.predTaken;
        predAddr      = x.predAddr;
        stall         = 1'b0;
        clear         = 1'b0;
        flushValid    = 1'b0;
    endtask

    initial begin
        wait (tableReady);
        repeat (rows.size() * 4 + 50) @(posedge clk);
        $display("Timeout: the test table did not finish in the expected number of cycles");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        Row held;
        void'($urandom(32'h40f2));
        rstN = 1'b0;
        issueValid = 1'b0;
        opType = INT_OP_ALU;
        subInfo = '0;
        pc = '0;
        operandA = '0;
        operandAValid = 1'b0;
        operandB = '0;
        operandBValid = 1'b0;
        alPtr = '0;
        predTaken = 1'b0;
        predAddr = '0;
        stall = 1'b0;
        clear = 1'b0;
        flushValid = 1'b0;
        flushHead = '0;
        flushTail = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            driveIssue(rows[i]);
            @(negedge clk);
            issueValid = 1'b0;
            stall      = rows[i].stall;
            clear      = rows[i].clear;
            flushValid = rows[i].flushValid;
            flushHead  = rows[i].flushHead;
            flushTail  = rows[i].flushTail;
            #1;
            checkRow(i, rows[i]);
            if (rows[i].stall) begin
                // Held op comes back once stall drops
                @(negedge clk);
                stall = 1'b0;
                #1;
                held = rows[i];
                held.stall = 1'b0;
                held.expExValid = 1'b1;
                checkRow(i, held);
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/IntExecUnit_asserts.sv */
/*
 * Concurrent checks on the execution stage outputs, bound to the stage.
 */
`timescale 1ns/1ps
`default_nettype none

module IntExecUnitAsserts (
    input logic clk,
    input logic rstN,
    input logic exValid,
    input logic brValid,
    input logic brMispred
);

    // No result while reset holds
    assert property (@(posedge clk) !rstN |-> !exValid)
        else $error("exValid high during reset");

    assert property (@(posedge clk) disable iff (!rstN) brMispred |-> brValid)
        else $error("brMispred without brValid");

    assert property (@(posedge clk) disable iff (!rstN) brValid |-> exValid)
        else $error("brValid without exValid");

endmodule

`default_nettype wire

/* vlog.f */
common/IntExecPkg.sv
intExec/IntAlu.sv
intExec/IntShifter.sv
intExec/BranchResolver.sv
intExec/IntegerExecutionStage.sv
rtl/IntExecUnit.sv
tb/IntExecUnit_asserts.sv
tb/IntExecUnitTb.sv
